// File: source/smc_mac_pkg.sv
//--------------------------------------
// smc multiple access controller package
// transfer sizes, access counts, memory
// state codes and the shared bus word
// types for the 8-bit external bus
//--------------------------------------

package smc_mac_pkg;

  //--------------------------------------
  // widths
  //--------------------------------------

  localparam int BYTE_W = 8;   // external bus
  localparam int WORD_W = 32;  // internal bus word

  //--------------------------------------
  // transfer size codes
  //--------------------------------------

  typedef logic [1:0] xfer_size_t;

  localparam xfer_size_t XSIZ_8  = 2'd0;
  localparam xfer_size_t XSIZ_16 = 2'd1;
  localparam xfer_size_t XSIZ_32 = 2'd2;
  // code 3 unused, treated as a byte transfer

  //--------------------------------------
  // access counts
  //--------------------------------------

  // accesses still to come after the current one
  typedef logic [1:0] access_cnt_t;

  localparam access_cnt_t ACC_CNT_8  = 2'd0;  // one access
  localparam access_cnt_t ACC_CNT_16 = 2'd1;  // two accesses
  localparam access_cnt_t ACC_CNT_32 = 2'd3;  // four accesses

  // one-hot memory fsm state
  typedef logic [4:0] smc_state_t;

  localparam smc_state_t SMC_IDLE  = 5'b00001;
  localparam smc_state_t SMC_LE    = 5'b00010;  // latch enable
  localparam smc_state_t SMC_RW    = 5'b00100;  // read/write access
  localparam smc_state_t SMC_STORE = 5'b01000;  // wait on next transfer
  localparam smc_state_t SMC_FLOAT = 5'b10000;  // bus turnaround

  //--------------------------------------
  // bus word views
  //--------------------------------------

  typedef struct packed {
    logic [WORD_W/2-1:0] hi;
    logic [WORD_W/2-1:0] lo;
  } word_halves_t;

  // byte lanes while assembling, halves for 16-bit replication
  typedef union packed {
    logic [3:0][BYTE_W-1:0] bytes;
    word_halves_t           halves;
  } bus_word_u;

  // sequencer to read assembler
  typedef struct packed {
    xfer_size_t  size;   // registered transfer size
    access_cnt_t count;  // same as r_num_access
  } mac_access_t;

endpackage

// File: source/smc_access_sequencer.sv
//--------------------------------------
// smc access sequencer
// stores the transfer size, counts down
// the byte accesses of one transfer and
// steers the write byte to the 8-bit bus
//--------------------------------------

module smc_access_sequencer (
  input  logic                              sys_clk20,
  input  logic                              n_sys_reset20,   // active low
  input  logic                              valid_access,    // address cycle pulse
  input  smc_mac_pkg::xfer_size_t           xfer_size,       // valid with valid_access
  input  logic                              smc_done,        // end of one access
  input  smc_mac_pkg::smc_state_t           smc_nextstate,
  input  logic [smc_mac_pkg::WORD_W-1:0]    write_data,      // held by internal bus
  output smc_mac_pkg::mac_access_t          access,
  output logic                              mac_done,
  output smc_mac_pkg::xfer_size_t           v_xfer_size,
  output logic [smc_mac_pkg::WORD_W-1:0]    smc_data
);

  import smc_mac_pkg::*;

  xfer_size_t  r_xfer_size;      // size of transfer in progress
  access_cnt_t num_accesses;     // load value from incoming size
  access_cnt_t r_num_access;     // accesses left after this one
  logic        continue_access;  // fsm goes on to another access

  //--------------------------------------
  // transfer size
  //--------------------------------------

  always_ff @(posedge sys_clk20 or negedge n_sys_reset20)
  begin
    if (!n_sys_reset20)
      r_xfer_size <= XSIZ_8;
    else if (valid_access)
      r_xfer_size <= xfer_size;
  end

  // live size in the address cycle, stored size after
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  //--------------------------------------
  // access count
  //--------------------------------------

  always_comb
  begin
    case (xfer_size)
      XSIZ_16: num_accesses = ACC_CNT_16;
      XSIZ_32: num_accesses = ACC_CNT_32;
      default: num_accesses = ACC_CNT_8;   // byte and spare code
    endcase
  end

  // store or idle next means the transfer is over or stalled
  assign continue_access = smc_done &&
                           (smc_nextstate != SMC_STORE) &&
                           (smc_nextstate != SMC_IDLE);

  always_ff @(posedge sys_clk20 or negedge n_sys_reset20)
  begin
    if (!n_sys_reset20)
      r_num_access <= '0;
    else if (valid_access)
      r_num_access <= num_accesses;
    else if (continue_access)
      r_num_access <= r_num_access - 2'd1;
  end

  // last access of the transfer
  assign mac_done = (r_num_access == '0);

  assign access.size  = r_xfer_size;
  assign access.count = r_num_access;

  //--------------------------------------
  // write byte steering
  //--------------------------------------

  // most significant byte goes out first, count 3 -> byte 3
  always_comb
  begin
    smc_data = '0;   // upper lanes stay zero
    case (r_num_access)
      2'd3: smc_data[BYTE_W-1:0] = write_data[4*BYTE_W-1:3*BYTE_W];
      2'd2: smc_data[BYTE_W-1:0] = write_data[3*BYTE_W-1:2*BYTE_W];
      2'd1: smc_data[BYTE_W-1:0] = write_data[2*BYTE_W-1:BYTE_W];
      default: smc_data[BYTE_W-1:0] = write_data[BYTE_W-1:0];
    endcase
  end

endmodule

// File: source/smc_read_assembler.sv
//--------------------------------------
// smc read assembler
// builds the read word from external
// bytes, msb first, and replicates
// narrow reads over the internal bus
//--------------------------------------

module smc_read_assembler (
  input  logic                              sys_clk20,
  input  logic                              n_sys_reset20,  // active low
  input  smc_mac_pkg::mac_access_t          access,         // size and count
  input  logic                              latch_data,     // read byte valid
  input  logic [smc_mac_pkg::WORD_W-1:0]    data_smc,       // low lane only
  output logic [smc_mac_pkg::WORD_W-1:0]    read_data
);

  import smc_mac_pkg::*;

  bus_word_u         r_read_word;  // partly built word
  bus_word_u         cur_word;     // held word with live byte merged
  bus_word_u         rd_word;      // replicated by size
  logic [BYTE_W-1:0] live_byte;

  assign live_byte = data_smc[BYTE_W-1:0];

  //--------------------------------------
  // assembly
  //--------------------------------------

  // each access fills the next lower lane and clears below it
  always_ff @(posedge sys_clk20 or negedge n_sys_reset20)
  begin
    if (!n_sys_reset20)
    begin
      r_read_word <= '0;
    end
    else if (latch_data)
    begin
      case (access.count)
        2'd3:
        begin
          r_read_word.bytes[3]   <= live_byte;
          r_read_word.bytes[2:0] <= '0;
        end
        2'd2:
        begin
          r_read_word.bytes[2]   <= live_byte;
          r_read_word.bytes[1:0] <= '0;
        end
        2'd1:
        begin
          r_read_word.bytes[1] <= live_byte;
          r_read_word.bytes[0] <= '0;
        end
        default:
        begin
          r_read_word.bytes[0] <= live_byte;   // last byte, upper lanes kept
        end
      endcase
    end
  end

  //--------------------------------------
  // read data to internal bus
  //--------------------------------------

  // live byte bypasses the register in the latch cycle
  always_comb
  begin
    cur_word = r_read_word;
    if (latch_data)
      cur_word.bytes[0] = live_byte;
  end

  always_comb
  begin
    rd_word = cur_word;
    case (access.size)
      XSIZ_32:
      begin
        rd_word = cur_word;   // full word as built
      end
      XSIZ_16:
      begin
        rd_word.halves.hi = cur_word.halves.lo;   // half in both positions
        rd_word.halves.lo = cur_word.halves.lo;
      end
      default:
      begin
        // byte in all four lanes
        for (int i = 0; i < 4; i++)
          rd_word.bytes[i] = cur_word.bytes[0];
      end
    endcase
  end

  assign read_data = rd_word;

endmodule

// File: source/smc_mac_top.sv
//--------------------------------------
// smc multiple access controller
// serves one 8/16/32-bit transfer with
// one, two or four 8-bit accesses
//--------------------------------------

module smc_mac_top (
  input  logic                              sys_clk20,
  input  logic                              n_sys_reset20,  // active low
  input  logic                              valid_access,   // new transfer
  input  smc_mac_pkg::xfer_size_t           xfer_size,
  input  logic                              smc_done,       // access finished
  input  smc_mac_pkg::smc_state_t           smc_nextstate,
  input  logic                              latch_data,     // read byte valid
  input  logic [smc_mac_pkg::WORD_W-1:0]    data_smc,       // external read data
  input  logic [smc_mac_pkg::WORD_W-1:0]    write_data,     // internal write word
  output smc_mac_pkg::access_cnt_t          r_num_access,
  output logic                              mac_done,       // last access
  output smc_mac_pkg::xfer_size_t           v_xfer_size,
  output logic [smc_mac_pkg::WORD_W-1:0]    read_data,      // to internal bus
  output logic [smc_mac_pkg::WORD_W-1:0]    smc_data        // to external bus
);

  import smc_mac_pkg::*;

  mac_access_t access;   // size and count to the read path

  smc_access_sequencer u_sequencer (
    .sys_clk20     (sys_clk20),
    .n_sys_reset20 (n_sys_reset20),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .write_data    (write_data),
    .access        (access),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size),
    .smc_data      (smc_data)
  );

  smc_read_assembler u_assembler (
    .sys_clk20     (sys_clk20),
    .n_sys_reset20 (n_sys_reset20),
    .access        (access),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .read_data     (read_data)
  );

  assign r_num_access = access.count;   // counter seen by the fsm

endmodule

// File: tb/tb_smc_mac_table.svh
//--------------------------------------
// smc mac testbench transfer table
// directed rows, one transfer per row
//--------------------------------------

`ifndef TB_SMC_MAC_TABLE_SVH
`define TB_SMC_MAC_TABLE_SVH

localparam int NUM_ROWS = 10;

xfer_row_t rows [NUM_ROWS];

// columns: is_read, size, data, expected word
// read data byte for count c sits in data[8c+7:8c]
// write expected word keeps only the lanes put on the bus
task automatic load_table();
  rows[0] = '{1'b1, XSIZ_8,  32'h0000_005a, 32'h5a5a_5a5a};
  rows[1] = '{1'b1, XSIZ_16, 32'h0000_c3e1, 32'hc3e1_c3e1};
  rows[2] = '{1'b1, XSIZ_32, 32'h1234_5678, 32'h1234_5678};
  rows[3] = '{1'b0, XSIZ_8,  32'hdead_beef, 32'h0000_00ef};
  rows[4] = '{1'b0, XSIZ_16, 32'hdead_beef, 32'h0000_beef};
  rows[5] = '{1'b0, XSIZ_32, 32'hdead_beef, 32'hdead_beef};
  rows[6] = '{1'b1, XSIZ_32, 32'ha5f0_0f5a, 32'ha5f0_0f5a};
  rows[7] = '{1'b1, XSIZ_8,  32'h0000_0081, 32'h8181_8181};  // upper bytes still held
  rows[8] = '{1'b0, XSIZ_32, 32'h0102_0304, 32'h0102_0304};
  rows[9] = '{1'b1, XSIZ_16, 32'h0000_7e18, 32'h7e18_7e18};
endtask

`endif

// File: tb/tb_smc_mac.sv
//--------------------------------------
// smc mac testbench
// plays read and write transfers from a
// table plus random rows, checks count,
// done, size, read word and write byte
//--------------------------------------

module tb_smc_mac;

  timeunit 1ns;
  timeprecision 1ps;

  import smc_mac_pkg::*;

  typedef struct packed {
    logic        is_read;
    xfer_size_t  size;
    logic [31:0] data;      // read bytes or write word
    logic [31:0] exp_word;  // expected read word or written lanes
  } xfer_row_t;

  `include "tb_smc_mac_table.svh"

  localparam int NUM_RAND     = 6;
  localparam int RESET_CYCLES = 8;
  // at most 7 cycles per transfer
  localparam int CYCLE_LIMIT  = (NUM_ROWS + NUM_RAND) * 7 + RESET_CYCLES + 20;

  logic        sys_clk20 = 1'b0;
  logic        n_sys_reset20;
  logic        valid_access;
  xfer_size_t  xfer_size;
  logic        smc_done;
  smc_state_t  smc_nextstate;
  logic        latch_data;
  logic [31:0] data_smc;
  logic [31:0] write_data;
  access_cnt_t r_num_access;
  logic        mac_done;
  xfer_size_t  v_xfer_size;
  logic [31:0] read_data;
  logic [31:0] smc_data;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;

  smc_mac_top UUT (.*);

  always #5ns sys_clk20 = ~sys_clk20;

  //--------------------------------------
  // checking
  //--------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // expected word straight from the size rules
  function automatic logic [31:0] expected_word(input logic is_read, input xfer_size_t size,
                                                input logic [31:0] data);
    case (size)
      XSIZ_32: expected_word = data;
      XSIZ_16: expected_word = is_read ? {2{data[15:0]}} : {16'h0, data[15:0]};
      default: expected_word = is_read ? {4{data[7:0]}} : {24'h0, data[7:0]};
    endcase
  endfunction

  //--------------------------------------
  // one transfer
  //--------------------------------------

  task automatic run_transfer(input xfer_row_t row, input int idx);
    int          n_acc;
    access_cnt_t cnt;
    n_acc = (row.size == XSIZ_32) ? 4 : (row.size == XSIZ_16) ? 2 : 1;
    // address cycle
    @(posedge sys_clk20);
    valid_access <= 1'b1;
    xfer_size    <= row.size;
    write_data   <= row.data;   // held for the whole transfer
    @(negedge sys_clk20);
    check_value("v_xfer_size", v_xfer_size, row.size);
    // stalled access, count must hold
    @(posedge sys_clk20);
    valid_access  <= 1'b0;
    xfer_size     <= ~row.size;  // bus garbage, stored size must win
    smc_done      <= 1'b1;
    smc_nextstate <= idx[0] ? SMC_STORE : SMC_IDLE;
    @(negedge sys_clk20);
    check_value("r_num_access", r_num_access, n_acc - 1);
    check_value("mac_done", mac_done, n_acc == 1);
    check_value("v_xfer_size", v_xfer_size, row.size);
    for (int a = 0; a < n_acc; a++)
    begin
      cnt = access_cnt_t'(n_acc - 1 - a);
      @(posedge sys_clk20);
      smc_done      <= 1'b1;
      smc_nextstate <= (a == n_acc - 1) ? SMC_STORE : SMC_RW;
      latch_data    <= row.is_read;
      data_smc      <= {24'h0, row.data[8*cnt +: 8]};
      @(negedge sys_clk20);
      check_value("r_num_access", r_num_access, cnt);
      check_value("mac_done", mac_done, cnt == 0);
      check_value("v_xfer_size", v_xfer_size, row.size);
      if (!row.is_read)
        check_value("smc_data", smc_data, {24'h0, row.exp_word[8*cnt +: 8]});
      else if (a == n_acc - 1)
        check_value("read_data", read_data, row.exp_word);   // live byte merged
    end
    // idle cycle
    @(posedge sys_clk20);
    smc_done      <= 1'b0;
    latch_data    <= 1'b0;
    smc_nextstate <= SMC_IDLE;
    data_smc      <= 32'hffff_ffff;   // must not reach read_data
    @(negedge sys_clk20);
    check_value("r_num_access", r_num_access, 0);
    check_value("mac_done", mac_done, 1'b1);
    if (row.is_read)
      check_value("read_data", read_data, row.exp_word);
  endtask

  //--------------------------------------
  // main sequence
  //--------------------------------------

  initial
  begin
    xfer_row_t   row;
    int unsigned pick;
    seed          = 32'hb9e2_bb69;
    n_sys_reset20 = 1'b0;
    valid_access  = 1'b0;
    xfer_size     = XSIZ_8;
    smc_done      = 1'b0;
    smc_nextstate = SMC_IDLE;
    latch_data    = 1'b0;
    data_smc      = '0;
    write_data    = 32'hcafe_f00d;
    load_table();
    repeat (RESET_CYCLES) @(posedge sys_clk20);
    n_sys_reset20 <= 1'b1;
    @(negedge sys_clk20);
    // reset state
    check_value("r_num_access", r_num_access, 0);
    check_value("mac_done", mac_done, 1'b1);
    check_value("v_xfer_size", v_xfer_size, XSIZ_8);
    check_value("read_data", read_data, 32'h0);
    check_value("smc_data", smc_data, 32'h0000_000d);   // byte 0 of write word
    for (int i = 0; i < NUM_ROWS; i++)
      run_transfer(rows[i], i);
    // random rows
    for (int i = 0; i < NUM_RAND; i++)
    begin
      pick        = {$random(seed)} % 3;
      row.size    = (pick == 0) ? XSIZ_8 : (pick == 1) ? XSIZ_16 : XSIZ_32;
      row.is_read = $random(seed);
      row.data    = $random(seed);
      row.exp_word = expected_word(row.is_read, row.size, row.data);
      run_transfer(row, NUM_ROWS + i);
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // run limit
  always @(posedge sys_clk20)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: transfers did not finish within %0d cycles", CYCLE_LIMIT);
      $display("checks: %0d  errors: %0d", checks, errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule

// File: list.f
+incdir+tb
source/smc_mac_pkg.sv
source/smc_access_sequencer.sv
source/smc_read_assembler.sv
source/smc_mac_top.sv
tb/tb_smc_mac.sv

// File: Bender.yml
package:
  name: smc_mac

sources:
  # rtl, package first
  - files:
      - source/smc_mac_pkg.sv
      - source/smc_access_sequencer.sv
      - source/smc_read_assembler.sv
      - source/smc_mac_top.sv

  # testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_smc_mac.sv
